//--- vlog.f
src/periph_pkg.sv
src/apb_decoder.sv
src/gpio_apb.sv
src/systick_timer_apb.sv
src/intc_apb.sv
src/periph_top.sv
tests/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_subsys

sources:
  - src/periph_pkg.sv
  - src/apb_decoder.sv
  - src/gpio_apb.sv
  - src/systick_timer_apb.sv
  - src/intc_apb.sv
  - src/periph_top.sv
  - target: test
    files:
      - tests/tb_periph_top.sv

//--- tests/tb_periph_top.sv
// Testbench for the peripheral subsystem.
// Drives the APB port on the falling clock edge with random stimulus from a
// fixed seed and checks GPIO, timer, interrupt controller and decoder
// against a register model kept here. Prints one line per test, then a
// summary line and the final verdict.

`timescale 1ns/10ps
`default_nettype none

module tb_periph_top
   import periph_pkg::*;
();

   localparam int SEED      = 44306;
   localparam int HALF_NS   = 5;
   localparam int RESET_CYC = 10;
   localparam int N_DATA    = 8;                 // GPIO data rounds
   localparam int N_GIRQ    = 6;                 // GPIO interrupt rounds
   localparam int N_TMR     = 4;                 // Timer rounds
   localparam int N_INTC    = 8;
   localparam int N_UNMAP   = 8;
   localparam int XFER_NS   = 200 * 3 * 2 * HALF_NS;          // 200 transfers
   localparam int TIMER_NS  = N_TMR * 2 * 41 * 2 * HALF_NS;   // Longest timer waits
   localparam int WATCHDOG_NS = ((XFER_NS + TIMER_NS) / 20_000 + 1) * 20_000;

   logic                  clk = 1'b0;
   logic                  arst_n;
   logic [APB_AW-1:0]     paddr;
   logic                  psel, penable, pwrite;
   logic [APB_DW-1:0]     pwdata;
   logic [GPIO_WIDTH-1:0] gpio_in;
   logic                  irq_ext;
   logic [APB_DW-1:0]     prdata;
   logic                  pready, pslverr;
   logic [GPIO_WIDTH-1:0] gpio_out;
   logic                  irq;

   // Register model
   logic [GPIO_WIDTH-1:0] m_dout = '0, m_din = '0, m_gpio_en = '0, m_gpio_stat = '0;
   logic                  m_tmr_en = 1'b0, m_tmr_stat = 1'b0, m_ext = 1'b0;
   logic [APB_DW-1:0]     m_reload = '0, m_count = '0;
   irq_vec_t              m_intc_en = '0;

   string       cur_test;
   int          test_errs = 0, total_errs = 0, tests_run = 0, tests_failed = 0;
   int unsigned cycle_cnt = 0;

   periph_top periph_top_i (
      .clk_i(clk), .arst_n_i(arst_n), .paddr_i(paddr), .psel_i(psel),
      .penable_i(penable), .pwrite_i(pwrite), .pwdata_i(pwdata),
      .gpio_i(gpio_in), .irq_ext_i(irq_ext), .prdata_o(prdata),
      .pready_o(pready), .pslverr_o(pslverr), .gpio_o(gpio_out), .irq_o(irq)
   );

   always #HALF_NS clk = ~clk;                   // 10 ns period
   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   function automatic logic [APB_AW-1:0] addr_of(input logic [3:0] sel,
                                                  input logic [OFF_W-1:0] off);
      return {sel, off};
   endfunction

   function automatic irq_vec_t model_src();
      irq_vec_t s;
      s            = '0;
      s[IRQ_GPIO]  = |m_gpio_stat;               // Any GPIO status bit
      s[IRQ_TIMER] = m_tmr_stat;
      s[IRQ_EXT]   = m_ext;
      return s;
   endfunction

   // Valid flag in bit 31, lowest enabled pending source below
   function automatic logic [APB_DW-1:0] model_active();
      irq_vec_t          act;
      logic [APB_DW-1:0] v;
      act = model_src() & m_intc_en;
      v   = '0;
      for (int i = 0; i < IRQ_NUM; i++) begin
         if (act[i] && !v[APB_DW-1]) v = 32'h8000_0000 | i;  // First hit only
      end
      return v;
   endfunction

   task automatic note_failure();
      test_errs++;
      total_errs++;
   endtask

   task automatic report_mismatch(input string what, input logic [APB_DW-1:0] exp,
                                  input logic [APB_DW-1:0] act);
      $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      note_failure();
   endtask

   task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                               input logic [APB_DW-1:0] wdata,
                               output logic [APB_DW-1:0] rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;                            // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;                            // Access phase
      #(HALF_NS - 1);                            // Just before the access edge
      rdata = prdata;
      err   = pslverr;
      if (pready !== 1'b1) begin
         $display("%s: pready was low in the access cycle to %h", cur_test, addr);
         note_failure();
      end
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
      logic [APB_DW-1:0] rd;
      logic              err;
      apb_transfer(1'b1, addr, data, rd, err);
      if (err !== 1'b0) begin
         $display("%s: slave error on a write to mapped address %h", cur_test, addr);
         note_failure();
      end
   endtask

   task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
      logic err;
      apb_transfer(1'b0, addr, '0, data, err);
      if (err !== 1'b0) begin
         $display("%s: slave error on a read from mapped address %h", cur_test, addr);
         note_failure();
      end
   endtask

   task automatic check_reg(input string what, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] exp);
      logic [APB_DW-1:0] rd;
      read_reg(addr, rd);
      if (rd !== exp) report_mismatch(what, exp, rd);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic check_all_regs();
      check_reg("DOUT", addr_of(SEL_GPIO, GPIO_DOUT), 32'(m_dout));
      check_reg("DIN", addr_of(SEL_GPIO, GPIO_DIN), 32'(m_din));
      check_reg("IRQ_EN", addr_of(SEL_GPIO, GPIO_IRQ_EN), 32'(m_gpio_en));
      check_reg("IRQ_STAT", addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'(m_gpio_stat));
      check_reg("CTRL", addr_of(SEL_TIMER, TMR_CTRL), 32'(m_tmr_en));
      check_reg("RELOAD", addr_of(SEL_TIMER, TMR_RELOAD), m_reload);
      check_reg("COUNT", addr_of(SEL_TIMER, TMR_COUNT), m_count);
      check_reg("TMR_STAT", addr_of(SEL_TIMER, TMR_STAT), 32'(m_tmr_stat));
      check_reg("ENABLE", addr_of(SEL_INTC, INTC_ENABLE), 32'(m_intc_en));
      check_reg("PENDING", addr_of(SEL_INTC, INTC_PENDING), 32'(model_src()));
      check_reg("ACTIVE", addr_of(SEL_INTC, INTC_ACTIVE), model_active());
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_errs = 0;
      tests_run++;
   endtask

   task automatic end_test();
      if (test_errs == 0) begin
         $display("test %s passed", cur_test);
      end else begin
         $display("test %s failed with %0d errors", cur_test, test_errs);
         tests_failed++;
      end
   endtask

   task automatic test_gpio_data();
      logic [APB_DW-1:0] d;
      begin_test("reset_gpio_data");
      check_all_regs();                          // Model is all zero here
      if (gpio_out !== '0) report_mismatch("gpio_o after reset", '0, 32'(gpio_out));
      for (int n = 0; n < N_DATA; n++) begin
         d      = $urandom;
         m_dout = d[GPIO_WIDTH-1:0];
         write_reg(addr_of(SEL_GPIO, GPIO_DOUT), d);
         if (gpio_out !== m_dout) report_mismatch("gpio_o", 32'(m_dout), 32'(gpio_out));
         check_reg("DOUT", addr_of(SEL_GPIO, GPIO_DOUT), 32'(m_dout));
      end
      for (int n = 0; n < N_DATA; n++) begin
         @(negedge clk);
         m_din   = GPIO_WIDTH'($urandom);
         gpio_in = m_din;
         wait_cycles(3);                         // Synchronizer latency
         check_reg("DIN", addr_of(SEL_GPIO, GPIO_DIN), 32'(m_din));
      end
      end_test();
   endtask

   task automatic test_gpio_irq();
      logic [GPIO_WIDTH-1:0] v, clr;
      begin_test("gpio_irq");
      for (int n = 0; n < N_GIRQ; n++) begin
         @(negedge clk);
         gpio_in = '0;                           // Falling pins set nothing
         m_din   = '0;
         wait_cycles(4);
         write_reg(addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'hFFFF);
         m_gpio_stat = '0;
         m_gpio_en   = GPIO_WIDTH'($urandom);
         write_reg(addr_of(SEL_GPIO, GPIO_IRQ_EN), 32'(m_gpio_en));
         v = GPIO_WIDTH'($urandom);
         @(negedge clk);
         gpio_in     = v;
         m_din       = v;
         m_gpio_stat = v & m_gpio_en;            // Enabled rising pins
         wait_cycles(4);
         check_reg("IRQ_STAT", addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'(m_gpio_stat));
         check_reg("PENDING", addr_of(SEL_INTC, INTC_PENDING), 32'(model_src()));
         clr = GPIO_WIDTH'($urandom);
         write_reg(addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'(clr));
         m_gpio_stat = m_gpio_stat & ~clr;       // Ones clear
         check_reg("IRQ_STAT cleared", addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'(m_gpio_stat));
      end
      end_test();
   endtask

   task automatic test_timer();
      logic [APB_DW-1:0] r, c1, c2;
      int unsigned       start;
      begin_test("timer");
      for (int n = 0; n < N_TMR; n++) begin
         r = 4 + ($urandom % 37);                // Reload 4 to 40
         write_reg(addr_of(SEL_TIMER, TMR_CTRL), 32'h0);
         write_reg(addr_of(SEL_TIMER, TMR_STAT), 32'h1);
         m_tmr_stat = 1'b0;
         write_reg(addr_of(SEL_TIMER, TMR_RELOAD), r);
         m_reload = r;
         write_reg(addr_of(SEL_TIMER, TMR_CTRL), 32'h1);
         m_tmr_en = 1'b1;
         start    = cycle_cnt;
         check_reg("STAT early", addr_of(SEL_TIMER, TMR_STAT), 32'h0);
         while (cycle_cnt - start < 2 * (r + 1)) begin
            read_reg(addr_of(SEL_TIMER, TMR_COUNT), c1);
            if (c1 > r) report_mismatch("COUNT above RELOAD", r, c1);
         end
         m_tmr_stat = 1'b1;                      // Expired at least once
         check_reg("STAT expired", addr_of(SEL_TIMER, TMR_STAT), 32'h1);
         write_reg(addr_of(SEL_TIMER, TMR_CTRL), 32'h0);
         m_tmr_en = 1'b0;
         read_reg(addr_of(SEL_TIMER, TMR_COUNT), c1);
         read_reg(addr_of(SEL_TIMER, TMR_COUNT), c2);
         if (c2 !== c1) report_mismatch("COUNT frozen", c1, c2);
         m_count = c2;
      end
      end_test();
   endtask

   task automatic test_intc();
      logic [GPIO_WIDTH-1:0] clr;
      logic                  exp_irq;
      begin_test("intc");
      for (int n = 0; n < N_INTC; n++) begin
         @(negedge clk);
         m_ext   = 1'($urandom);
         irq_ext = m_ext;
         clr     = GPIO_WIDTH'($urandom) & GPIO_WIDTH'($urandom);  // Sparse clear
         write_reg(addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'(clr));
         m_gpio_stat = m_gpio_stat & ~clr;
         if (n == N_INTC / 2) begin
            write_reg(addr_of(SEL_TIMER, TMR_STAT), 32'h1);        // Drop the timer source
            m_tmr_stat = 1'b0;
         end
         m_intc_en = IRQ_NUM'($urandom);
         write_reg(addr_of(SEL_INTC, INTC_ENABLE), 32'(m_intc_en));
         wait_cycles(4);
         exp_irq = |(model_src() & m_intc_en);
         if (irq !== exp_irq) report_mismatch("irq_o", 32'(exp_irq), 32'(irq));
         check_reg("PENDING", addr_of(SEL_INTC, INTC_PENDING), 32'(model_src()));
         check_reg("ACTIVE", addr_of(SEL_INTC, INTC_ACTIVE), model_active());
      end
      end_test();
   endtask

   task automatic test_unmapped();
      logic [3:0]        sel;
      logic [OFF_W-1:0]  off;
      logic [APB_DW-1:0] d;
      logic              err;
      begin_test("unmapped");
      for (int n = 0; n < N_UNMAP; n++) begin
         sel = 4'(3 + ($urandom % 13));          // Codes 3 to 15
         off = OFF_W'(($urandom % 4) * 4);
         apb_transfer(1'b1, addr_of(sel, off), $urandom, d, err);
         if (err !== 1'b1) report_mismatch("pslverr on write", 32'h1, 32'(err));
         apb_transfer(1'b0, addr_of(sel, off), '0, d, err);
         if (err !== 1'b1) report_mismatch("pslverr on read", 32'h1, 32'(err));
         if (d !== '0) report_mismatch("prdata on read", '0, d);
      end
      check_all_regs();                          // Nothing mapped moved
      end_test();
   endtask

   initial begin
      int unsigned seed_ret;
      seed_ret = $urandom(SEED);
      arst_n   = 1'b0;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = '0;
      gpio_in  = '0;
      irq_ext  = 1'b0;
      repeat (RESET_CYC) @(negedge clk);
      arst_n = 1'b1;
      test_gpio_data();
      test_gpio_irq();
      test_timer();
      test_intc();
      test_unmapped();
      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
               total_errs);
      if (total_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- src/periph_top.sv
// Top of the peripheral subsystem.
// The host drives APB directly. The decoder fans the selects out to the
// GPIO, the system tick timer and the interrupt controller, and returns
// read data and slave error. GPIO and timer interrupts enter the
// controller at their fixed source positions.

`timescale 1ns/10ps
`default_nettype none

module periph_top
   import periph_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  arst_n_i,
   input  wire logic [APB_AW-1:0]     paddr_i,
   input  wire logic                  psel_i,
   input  wire logic                  penable_i,
   input  wire logic                  pwrite_i,
   input  wire logic [APB_DW-1:0]     pwdata_i,
   input  wire logic [GPIO_WIDTH-1:0] gpio_i,
   input  wire logic                  irq_ext_i,
   output logic [APB_DW-1:0]          prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,
   output logic [GPIO_WIDTH-1:0]      gpio_o,
   output logic                       irq_o
);

   logic              gpio_psel, timer_psel, intc_psel;
   logic [APB_DW-1:0] gpio_prdata, timer_prdata, intc_prdata;
   logic              gpio_irq, timer_irq;
   irq_vec_t          irq_src;

   always_comb begin
      irq_src            = '0;          // External slot filled inside intc
      irq_src[IRQ_GPIO]  = gpio_irq;
      irq_src[IRQ_TIMER] = timer_irq;
   end

   apb_decoder apb_decoder_i (
      .clk_i, .arst_n_i, .paddr_i, .psel_i, .penable_i,
      .gpio_prdata_i (gpio_prdata),
      .timer_prdata_i(timer_prdata),
      .intc_prdata_i (intc_prdata),
      .gpio_psel_o   (gpio_psel),
      .timer_psel_o  (timer_psel),
      .intc_psel_o   (intc_psel),
      .prdata_o, .pready_o, .pslverr_o
   );

   gpio_apb gpio_apb_i (
      .clk_i, .arst_n_i, .psel_i(gpio_psel), .penable_i, .pwrite_i,
      .paddr_i(paddr_i[OFF_W-1:0]), .pwdata_i, .gpio_i,
      .prdata_o(gpio_prdata), .gpio_o, .irq_o(gpio_irq)
   );

   systick_timer_apb systick_timer_apb_i (
      .clk_i, .arst_n_i, .psel_i(timer_psel), .penable_i, .pwrite_i,
      .paddr_i(paddr_i[OFF_W-1:0]), .pwdata_i,
      .prdata_o(timer_prdata), .irq_o(timer_irq)
   );

   intc_apb intc_apb_i (
      .clk_i, .arst_n_i, .psel_i(intc_psel), .penable_i, .pwrite_i,
      .paddr_i(paddr_i[OFF_W-1:0]), .pwdata_i,
      .irq_src_i(irq_src), .irq_ext_i,
      .prdata_o(intc_prdata), .irq_o
   );

endmodule

`default_nettype wire

//--- src/intc_apb.sv
// Interrupt controller on the APB bus.
// Collects the peripheral levels and the synchronized external line into
// one source vector. ENABLE masks the sources, PENDING shows the raw
// levels and ACTIVE gives the lowest numbered enabled pending source with
// a valid flag in bit 31. irq_o is the registered OR of enabled sources.

`timescale 1ns/10ps
`default_nettype none

module intc_apb
   import periph_pkg::*;
(
   input  wire logic              clk_i,
   input  wire logic              arst_n_i,
   input  wire logic              psel_i,
   input  wire logic              penable_i,
   input  wire logic              pwrite_i,
   input  wire logic [OFF_W-1:0]  paddr_i,
   input  wire logic [APB_DW-1:0] pwdata_i,
   input  wire irq_vec_t          irq_src_i,
   input  wire logic              irq_ext_i,
   output logic [APB_DW-1:0]      prdata_o,
   output logic                   irq_o
);

   logic                 wr_en;
   logic                 ext_s1_q, ext_s2_q;  // External line synchronizer
   irq_vec_t             pending;
   irq_vec_t             enable_q;
   irq_vec_t             masked;
   logic                 act_valid;
   logic [IRQ_IDX_W-1:0] act_idx;
   logic                 irq_q;

   assign wr_en = psel_i && penable_i && pwrite_i;

   always_comb begin
      pending          = irq_src_i;
      pending[IRQ_EXT] = irq_src_i[IRQ_EXT] | ext_s2_q; // External joins here
   end

   assign masked    = pending & enable_q;
   assign act_valid = |masked;

   // Priority encoder, lowest number wins
   always_comb begin
      act_idx = '0;
      for (int i = IRQ_NUM - 1; i >= 0; i--) begin
         if (masked[i]) act_idx = IRQ_IDX_W'(i);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ext_s1_q <= 1'b0;
         ext_s2_q <= 1'b0;
         enable_q <= '0;
         irq_q    <= 1'b0;
      end else begin
         ext_s1_q <= irq_ext_i;
         ext_s2_q <= ext_s1_q;
         irq_q    <= act_valid;                      // One cycle behind
         if (wr_en && paddr_i == INTC_ENABLE) enable_q <= pwdata_i[IRQ_NUM-1:0];
      end
   end

   assign irq_o = irq_q;

   always_comb begin
      prdata_o = '0;
      case (paddr_i)
         INTC_ENABLE:  prdata_o[IRQ_NUM-1:0] = enable_q;
         INTC_PENDING: prdata_o[IRQ_NUM-1:0] = pending;  // Unmasked levels
         INTC_ACTIVE: begin
            prdata_o[APB_DW-1]      = act_valid;
            prdata_o[IRQ_IDX_W-1:0] = act_idx;
         end
         default:      prdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/systick_timer_apb.sv
// System tick timer on the APB bus.
// A down counter runs while CTRL bit 0 is set. At zero it reloads from
// RELOAD and sets the sticky STAT bit, so the period is RELOAD+1 cycles.
// Writing RELOAD also loads the counter. Write a one to STAT to clear it.
// irq_o follows STAT.

`timescale 1ns/10ps
`default_nettype none

module systick_timer_apb
   import periph_pkg::*;
(
   input  wire logic              clk_i,
   input  wire logic              arst_n_i,
   input  wire logic              psel_i,
   input  wire logic              penable_i,
   input  wire logic              pwrite_i,
   input  wire logic [OFF_W-1:0]  paddr_i,
   input  wire logic [APB_DW-1:0] pwdata_i,
   output logic [APB_DW-1:0]      prdata_o,
   output logic                   irq_o
);

   logic              wr_en;
   logic              enable_q;        // CTRL bit 0
   logic [APB_DW-1:0] reload_q;
   logic [APB_DW-1:0] count_q;
   logic              stat_q;          // Sticky expiry flag
   logic              expire;

   assign wr_en  = psel_i && penable_i && pwrite_i;
   assign expire = enable_q && (count_q == '0);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         enable_q <= 1'b0;
         reload_q <= '0;
      end else begin
         if (wr_en && paddr_i == TMR_CTRL)   enable_q <= pwdata_i[0];
         if (wr_en && paddr_i == TMR_RELOAD) reload_q <= pwdata_i;
      end
   end

   // Down counter where a RELOAD write beats counting
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q <= '0;
      end else if (wr_en && paddr_i == TMR_RELOAD) begin
         count_q <= pwdata_i;
      end else if (expire) begin
         count_q <= reload_q;          // Wrap
      end else if (enable_q) begin
         count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stat_q <= 1'b0;
      end else if (expire) begin
         stat_q <= 1'b1;               // Expiry beats a clear
      end else if (wr_en && paddr_i == TMR_STAT && pwdata_i[0]) begin
         stat_q <= 1'b0;
      end
   end

   assign irq_o = stat_q;

   always_comb begin
      prdata_o = '0;
      case (paddr_i)
         TMR_CTRL:   prdata_o[0] = enable_q;
         TMR_RELOAD: prdata_o    = reload_q;
         TMR_COUNT:  prdata_o    = count_q;   // Live value
         TMR_STAT:   prdata_o[0] = stat_q;
         default:    prdata_o    = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/gpio_apb.sv
// GPIO block on the APB bus.
// DOUT drives the pins straight from a register. Inputs pass a two-flop
// synchronizer before DIN reads them. Rising edges on pins enabled in
// IRQ_EN latch into IRQ_STAT; writing ones to IRQ_STAT clears them.
// irq_o is a level, high while any status bit is set.

`timescale 1ns/10ps
`default_nettype none

module gpio_apb
   import periph_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  arst_n_i,
   input  wire logic                  psel_i,
   input  wire logic                  penable_i,
   input  wire logic                  pwrite_i,
   input  wire logic [OFF_W-1:0]      paddr_i,
   input  wire logic [APB_DW-1:0]     pwdata_i,
   input  wire logic [GPIO_WIDTH-1:0] gpio_i,
   output logic [APB_DW-1:0]          prdata_o,
   output logic [GPIO_WIDTH-1:0]      gpio_o,
   output logic                       irq_o
);

   logic                  wr_en;
   logic [GPIO_WIDTH-1:0] dout_q;
   logic [GPIO_WIDTH-1:0] sync1_q, sync2_q;   // Input synchronizer
   logic [GPIO_WIDTH-1:0] prev_q;             // Last synced value for edges
   logic [GPIO_WIDTH-1:0] irq_en_q;
   logic [GPIO_WIDTH-1:0] irq_stat_q;
   logic [GPIO_WIDTH-1:0] rise;

   assign wr_en = psel_i && penable_i && pwrite_i;
   assign rise  = sync2_q & ~prev_q & irq_en_q; // Enabled pins only

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dout_q     <= '0;
         sync1_q    <= '0;
         sync2_q    <= '0;
         prev_q     <= '0;
         irq_en_q   <= '0;
         irq_stat_q <= '0;
      end else begin
         sync1_q <= gpio_i;
         sync2_q <= sync1_q;
         prev_q  <= sync2_q;
         if (wr_en && paddr_i == GPIO_DOUT)   dout_q   <= pwdata_i[GPIO_WIDTH-1:0];
         if (wr_en && paddr_i == GPIO_IRQ_EN) irq_en_q <= pwdata_i[GPIO_WIDTH-1:0];
         if (wr_en && paddr_i == GPIO_IRQ_STAT) begin
            irq_stat_q <= (irq_stat_q & ~pwdata_i[GPIO_WIDTH-1:0]) | rise; // New edge wins
         end else begin
            irq_stat_q <= irq_stat_q | rise;
         end
      end
   end

   assign gpio_o = dout_q;
   assign irq_o  = |irq_stat_q;

   always_comb begin
      prdata_o = '0;
      case (paddr_i)
         GPIO_DOUT:     prdata_o[GPIO_WIDTH-1:0] = dout_q;
         GPIO_DIN:      prdata_o[GPIO_WIDTH-1:0] = sync2_q;
         GPIO_IRQ_EN:   prdata_o[GPIO_WIDTH-1:0] = irq_en_q;
         GPIO_IRQ_STAT: prdata_o[GPIO_WIDTH-1:0] = irq_stat_q;
         default:       prdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/apb_decoder.sv
// APB address decoder for the peripheral subsystem.
// Splits the host select into one select per peripheral from the
// top address nibble, muxes the read word back to the host and
// answers unmapped codes with a slave error and zero data.
// No wait states: pready is raised in every access cycle.

`timescale 1ns/10ps
`default_nettype none

module apb_decoder
   import periph_pkg::*;
(
   input  wire logic              clk_i,
   input  wire logic              arst_n_i,
   input  wire logic [APB_AW-1:0] paddr_i,
   input  wire logic              psel_i,
   input  wire logic              penable_i,
   input  wire logic [APB_DW-1:0] gpio_prdata_i,
   input  wire logic [APB_DW-1:0] timer_prdata_i,
   input  wire logic [APB_DW-1:0] intc_prdata_i,
   output logic                   gpio_psel_o,
   output logic                   timer_psel_o,
   output logic                   intc_psel_o,
   output logic [APB_DW-1:0]      prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o
);

   logic [SEL_MSB-SEL_LSB:0] sel_code;
   logic                     mapped;
   logic                     setup_q;       // Setup phase seen last cycle

   assign sel_code = paddr_i[SEL_MSB:SEL_LSB];
   assign mapped   = (sel_code == SEL_GPIO) || (sel_code == SEL_TIMER) ||
                     (sel_code == SEL_INTC);

   assign gpio_psel_o  = psel_i && (sel_code == SEL_GPIO);
   assign timer_psel_o = psel_i && (sel_code == SEL_TIMER);
   assign intc_psel_o  = psel_i && (sel_code == SEL_INTC);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= psel_i && !penable_i;   // Access phase follows setup
      end
   end

   assign pready_o  = psel_i && penable_i && setup_q;
   assign pslverr_o = pready_o && !mapped;  // Unmapped code

   always_comb begin
      case (sel_code)
         SEL_GPIO:  prdata_o = gpio_prdata_i;
         SEL_TIMER: prdata_o = timer_prdata_i;
         SEL_INTC:  prdata_o = intc_prdata_i;
         default:   prdata_o = '0;          // Zero on unmapped reads
      endcase
   end

endmodule

`default_nettype wire

//--- src/periph_pkg.sv
// Shared map and widths for the peripheral subsystem.
// Holds the APB address map, the register offsets of each peripheral,
// the GPIO width and the interrupt source numbering.
// Every RTL module takes it with a wildcard import in its header.

`default_nettype none

package periph_pkg;

   localparam int APB_AW  = 16;              // Host address width
   localparam int APB_DW  = 32;              // Data width
   localparam int SEL_MSB = 15;              // Peripheral select field
   localparam int SEL_LSB = 12;
   localparam int OFF_W   = SEL_LSB;         // Offset width seen by a peripheral

   localparam logic [3:0] SEL_GPIO  = 4'd0;
   localparam logic [3:0] SEL_TIMER = 4'd1;
   localparam logic [3:0] SEL_INTC  = 4'd2;  // Any other code is unmapped

   localparam int GPIO_WIDTH = 16;

   localparam logic [OFF_W-1:0] GPIO_DOUT     = 12'h000;
   localparam logic [OFF_W-1:0] GPIO_DIN      = 12'h004;
   localparam logic [OFF_W-1:0] GPIO_IRQ_EN   = 12'h008;
   localparam logic [OFF_W-1:0] GPIO_IRQ_STAT = 12'h00C;

   localparam logic [OFF_W-1:0] TMR_CTRL   = 12'h000;
   localparam logic [OFF_W-1:0] TMR_RELOAD = 12'h004;
   localparam logic [OFF_W-1:0] TMR_COUNT  = 12'h008;
   localparam logic [OFF_W-1:0] TMR_STAT   = 12'h00C;

   localparam logic [OFF_W-1:0] INTC_ENABLE  = 12'h000;
   localparam logic [OFF_W-1:0] INTC_PENDING = 12'h004;
   localparam logic [OFF_W-1:0] INTC_ACTIVE  = 12'h008;

   localparam int IRQ_NUM   = 3;
   localparam int IRQ_IDX_W = $clog2(IRQ_NUM); // Width of a source number
   localparam int IRQ_GPIO  = 0;               // Lowest number wins
   localparam int IRQ_TIMER = 1;
   localparam int IRQ_EXT   = 2;

   typedef logic [IRQ_NUM-1:0] irq_vec_t;      // One bit per source

endpackage

`default_nettype wire
